/* source/pipe_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared definitions for the two-lane pipeline
//   lane count and zero register index
//   lane opcodes and bundle kinds
//   lane, bundle and writeback structs
////////////////////////////////////////////////////////////////////////////

package pipe_pkg;

  localparam int num_lanes = 2;        // fixed lane count
  localparam int zero_reg  = 0;        // hardwired zero register

  // struct field widths follow the default top-level widths
  localparam int lane_idx_width  = 3;  // must equal idx_width of pipe_top
  localparam int lane_data_width = 16; // must equal data_width of pipe_top
  localparam int imm_width       = 16; // immediate field

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    op_nop = 3'd0,                     // no write
    op_add = 3'd1,                     // a + b, wraps
    op_sub = 3'd2,                     // a - b
    op_and = 3'd3,                     // a & b
    op_xor = 3'd4,                     // a ^ b
    op_ldi = 3'd5                      // load immediate
  } op_e;

  typedef enum logic [1:0] {
    bk_exec    = 2'd0,                 // normal two-lane bundle
    bk_save    = 2'd1,                 // snapshot the register file
    bk_restore = 2'd2                  // load the snapshot back
  } bundle_kind_e;

  ////////////////////////////////////////////////////////////////////////////
  // bundle and writeback
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    op_e                       op;     // lane opcode
    logic [lane_idx_width-1:0] dest;   // destination register
    logic [lane_idx_width-1:0] src_a;  // first source
    logic [lane_idx_width-1:0] src_b;  // second source
    logic [imm_width-1:0]      imm;    // immediate for op_ldi
  } lane_t;

  typedef struct packed {
    bundle_kind_e                kind; // exec, save or restore
    lane_t [num_lanes-1:0]       lane; // lane 1 is the upper slot
  } bundle_t;

  typedef struct packed {
    logic                       en;    // lane writes this cycle
    logic [lane_idx_width-1:0]  dest;  // target register
    logic [lane_data_width-1:0] data;  // result value
  } wb_lane_t;

  typedef struct packed {
    logic                     valid;   // one bundle retired
    wb_lane_t [num_lanes-1:0] lane;    // per-lane write port
  } wb_t;

endpackage

/* source/regfile.sv */
////////////////////////////////////////////////////////////////////////////
// two-lane physical register file
//   four combinational read ports, two per lane
//   register 0 hardwired to zero
//   bulk load from reg_vals_in on copy
//   full state out with the pending writeback forwarded
////////////////////////////////////////////////////////////////////////////

module regfile import pipe_pkg::*; #(
  parameter int idx_width  = 3,
  parameter int data_width = 16
) (
  input  logic                                     wr_clk,
  input  logic                                     reset,
  input  logic [num_lanes-1:0][idx_width-1:0]      rd_idx_a,     // port a index per lane
  input  logic [num_lanes-1:0][idx_width-1:0]      rd_idx_b,     // port b index per lane
  output logic [num_lanes-1:0][data_width-1:0]     rd_data_a,
  output logic [num_lanes-1:0][data_width-1:0]     rd_data_b,
  input  wb_t                                      wb,           // write port
  input  logic                                     copy,         // bulk load strobe
  input  logic [(2**idx_width)-1:0][data_width-1:0] reg_vals_in,
  output logic [(2**idx_width)-1:0][data_width-1:0] reg_vals_out
);

  localparam int reg_count = 2**idx_width;

  logic [data_width-1:0] regs [reg_count];  // storage

  ////////////////////////////////////////////////////////////////////////////
  // read ports
  ////////////////////////////////////////////////////////////////////////////

  // no bypass here, handshake spacing keeps reads behind the last write
  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      if (rd_idx_a[l] == zero_reg)
        rd_data_a[l] = '0;                // zero register
      else
        rd_data_a[l] = regs[rd_idx_a[l]];
      if (rd_idx_b[l] == zero_reg)
        rd_data_b[l] = '0;
      else
        rd_data_b[l] = regs[rd_idx_b[l]];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // state update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge wr_clk) begin
    for (int i = 0; i < reg_count; i++) begin
      if (i == zero_reg)
        regs[i] <= '0;                    // never written
      else if (reset)
        regs[i] <= '0;
      else if (copy)
        regs[i] <= reg_vals_in[i];        // restore from snapshot
      else begin
        for (int l = 0; l < num_lanes; l++) begin
          if (wb.lane[l].en && (wb.lane[l].dest == i))
            regs[i] <= wb.lane[l].data;   // later lane overrides
        end
      end
    end
  end

  // state as it will look after this edge's writeback
  always_comb begin
    for (int i = 0; i < reg_count; i++) begin
      reg_vals_out[i] = regs[i];
      for (int l = 0; l < num_lanes; l++) begin
        if (wb.lane[l].en && (wb.lane[l].dest == i))
          reg_vals_out[i] = wb.lane[l].data; // lane 1 last, same as the write
      end
      if (i == zero_reg)
        reg_vals_out[i] = '0;             // keep snapshot of r0 clean
    end
  end

endmodule

/* source/issue_stage.sv */
////////////////////////////////////////////////////////////////////////////
// issue stage
//   four-phase req/ack slave toward the producer
//   bundle stage register, loaded on capture
//   one-cycle iss_valid after each capture
////////////////////////////////////////////////////////////////////////////

module issue_stage import pipe_pkg::*; (
  input  logic    wr_clk,
  input  logic    reset,
  input  logic    req,          // producer request
  output logic    ack,          // slave acknowledge
  input  bundle_t bundle_in,    // stable while req is high
  output bundle_t iss_bundle,   // stage register
  output logic    iss_valid     // stage register holds a fresh bundle
);

  logic capture;                // req seen with ack still low

  assign capture = req && !ack;

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////////////////////

  // phase 1 req up, ack up on the same edge as the capture
  // phase 3 req down, ack down on the first edge that sees it
  always_ff @(posedge wr_clk) begin
    if (reset) begin
      ack       <= 1'b0;
      iss_valid <= 1'b0;
    end else begin
      iss_valid <= capture;     // exactly one cycle per bundle
      if (capture)
        ack <= 1'b1;            // bundle taken
      else if (!req)
        ack <= 1'b0;            // return to idle
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////////////////////

  // read only while iss_valid is high
  always_ff @(posedge wr_clk) begin
    if (capture)
      iss_bundle <= bundle_in;  // latch both lanes and the kind
  end

endmodule

/* source/exec_stage.sv */
////////////////////////////////////////////////////////////////////////////
// execute stage
//   per-lane alu for add, sub, and, xor and load immediate
//   writeback register toward the register file
//   save and restore pulses for the checkpoint unit
////////////////////////////////////////////////////////////////////////////

module exec_stage import pipe_pkg::*; #(
  parameter int data_width = 16
) (
  input  logic                                 wr_clk,
  input  logic                                 reset,
  input  bundle_t                              iss_bundle,
  input  logic                                 iss_valid,
  input  logic [num_lanes-1:0][data_width-1:0] rd_data_a,  // operand a per lane
  input  logic [num_lanes-1:0][data_width-1:0] rd_data_b,  // operand b per lane
  output wb_t                                  wb,
  output logic                                 save_pulse,
  output logic                                 restore_pulse
);

  localparam int idx_width_l = lane_idx_width;

  logic [num_lanes-1:0][data_width-1:0] result;   // alu outputs
  logic                                 valid_q;  // bundle retired
  logic [num_lanes-1:0]                 en_q;     // write enables
  logic [num_lanes-1:0][idx_width_l-1:0] dest_q;  // registered targets
  logic [num_lanes-1:0][data_width-1:0] data_q;   // registered results

  function automatic logic [data_width-1:0] lane_alu(
    input lane_t                 ln,
    input logic [data_width-1:0] a,
    input logic [data_width-1:0] b
  );
    case (ln.op)
      op_add:  return a + b;                      // wraps at data_width
      op_sub:  return a - b;
      op_and:  return a & b;
      op_xor:  return a ^ b;
      op_ldi:  return data_width'(ln.imm);        // truncate the immediate
      default: return '0;                         // op_nop has no result
    endcase
  endfunction

  always_comb begin
    for (int l = 0; l < num_lanes; l++)
      result[l] = lane_alu(iss_bundle.lane[l], rd_data_a[l], rd_data_b[l]);
  end

  ////////////////////////////////////////////////////////////////////////////
  // result register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge wr_clk) begin
    if (reset) begin
      valid_q       <= 1'b0;
      en_q          <= '0;
      save_pulse    <= 1'b0;
      restore_pulse <= 1'b0;
    end else begin
      valid_q       <= iss_valid;                 // every kind retires
      save_pulse    <= iss_valid && (iss_bundle.kind == bk_save);
      restore_pulse <= iss_valid && (iss_bundle.kind == bk_restore);
      for (int l = 0; l < num_lanes; l++)
        en_q[l] <= iss_valid && (iss_bundle.kind == bk_exec) &&
                   (iss_bundle.lane[l].op != op_nop);
    end
  end

  always_ff @(posedge wr_clk) begin
    if (iss_valid) begin
      for (int l = 0; l < num_lanes; l++) begin
        dest_q[l] <= iss_bundle.lane[l].dest;
        data_q[l] <= result[l];
      end
    end
  end

  // pack for the register file and wb_out
  always_comb begin
    wb.valid = valid_q;
    for (int l = 0; l < num_lanes; l++) begin
      wb.lane[l].en   = en_q[l];
      wb.lane[l].dest = dest_q[l];
      wb.lane[l].data = data_q[l];
    end
  end

endmodule

/* source/checkpoint_unit.sv */
////////////////////////////////////////////////////////////////////////////
// checkpoint unit
//   one snapshot of the whole register file
//   captured on save_pulse from the forwarded state
//   copy strobe and snapshot data on restore_pulse
////////////////////////////////////////////////////////////////////////////

module checkpoint_unit import pipe_pkg::*; #(
  parameter int idx_width  = 3,
  parameter int data_width = 16
) (
  input  logic                                      wr_clk,
  input  logic                                      reset,
  input  logic                                      save_pulse,    // from exec_stage
  input  logic                                      restore_pulse, // from exec_stage
  input  logic [(2**idx_width)-1:0][data_width-1:0] reg_vals_out,  // forwarded state
  output logic [(2**idx_width)-1:0][data_width-1:0] reg_vals_in,   // snapshot to regfile
  output logic                                      copy           // bulk load strobe
);

  localparam int reg_count = 2**idx_width;

  logic [reg_count-1:0][data_width-1:0] snapshot;  // saved register state

  ////////////////////////////////////////////////////////////////////////////
  // snapshot storage
  ////////////////////////////////////////////////////////////////////////////

  // reset value doubles as the state restored before any save
  always_ff @(posedge wr_clk) begin
    if (reset)
      snapshot <= '0;
    else if (save_pulse)
      snapshot <= reg_vals_out;  // includes the write in flight
  end

  assign reg_vals_in = snapshot;

  // restore_pulse is a flop output of exec_stage and lasts one cycle,
  // so the regfile loads the snapshot on the following edge
  assign copy = restore_pulse;  // one cycle, same as the pulse

endmodule

/* source/pipe_top.sv */
////////////////////////////////////////////////////////////////////////////
// pipeline top level
//   issue stage, register file, execute stage, checkpoint unit
//   sets the index and data widths for all blocks
////////////////////////////////////////////////////////////////////////////

module pipe_top import pipe_pkg::*; #(
  parameter int idx_width  = 3,   // 8 registers
  parameter int data_width = 16
) (
  input  logic    wr_clk,
  input  logic    reset,
  input  logic    req,            // producer handshake
  output logic    ack,
  input  bundle_t bundle_in,
  output wb_t     wb_out          // retired results
);

  localparam int reg_count = 2**idx_width;

  bundle_t                              iss_bundle;
  logic                                 iss_valid;
  logic [num_lanes-1:0][idx_width-1:0]  rd_idx_a;
  logic [num_lanes-1:0][idx_width-1:0]  rd_idx_b;
  logic [num_lanes-1:0][data_width-1:0] rd_data_a;
  logic [num_lanes-1:0][data_width-1:0] rd_data_b;
  wb_t                                  wb;
  logic                                 save_pulse;
  logic                                 restore_pulse;
  logic                                 copy;
  logic [reg_count-1:0][data_width-1:0] reg_vals_in;   // snapshot into regfile
  logic [reg_count-1:0][data_width-1:0] reg_vals_out;  // regfile into snapshot

  for (genvar l = 0; l < num_lanes; l++) begin : g_rd_idx
    assign rd_idx_a[l] = iss_bundle.lane[l].src_a;
    assign rd_idx_b[l] = iss_bundle.lane[l].src_b;
  end

  assign wb_out = wb;

  issue_stage u_issue (
    .wr_clk, .reset, .req, .ack, .bundle_in, .iss_bundle, .iss_valid
  );

  regfile #(.idx_width(idx_width), .data_width(data_width)) u_regfile (
    .wr_clk, .reset, .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
    .wb, .copy, .reg_vals_in, .reg_vals_out
  );

  exec_stage #(.data_width(data_width)) u_exec (
    .wr_clk, .reset, .iss_bundle, .iss_valid, .rd_data_a, .rd_data_b,
    .wb, .save_pulse, .restore_pulse
  );

  checkpoint_unit #(.idx_width(idx_width), .data_width(data_width)) u_ckpt (
    .wr_clk, .reset, .save_pulse, .restore_pulse, .reg_vals_out,
    .reg_vals_in, .copy
  );

endmodule

/* verification/pipe_checker.sv */
////////////////////////////////////////////////////////////////////////////
// concurrent assertions for the pipeline
//   register 0 stays zero
//   ack rises only after req
//   copy strobe is a single cycle
//   write enables low while in reset
////////////////////////////////////////////////////////////////////////////

module pipe_checker import pipe_pkg::*; #(
  parameter int data_width = 16
) (
  input logic                  wr_clk,
  input logic                  reset,
  input logic                  req,    // producer request
  input logic                  ack,    // issue stage acknowledge
  input logic                  copy,   // bulk load strobe
  input logic [data_width-1:0] r0,     // storage of register 0
  input wb_t                   wb      // regfile write port
);

  // hardwired zero, even across copy and lane writes to index 0
  r0_zero: assert property (@(posedge wr_clk) disable iff (reset) r0 == '0)
    else $error("register 0 holds a nonzero value");

  // four-phase slave answers a request only
  ack_after_req: assert property (@(posedge wr_clk) disable iff (reset)
    $rose(ack) |-> $past(req))
    else $error("ack rose without a request");

  copy_one_cycle: assert property (@(posedge wr_clk) disable iff (reset)
    copy |=> !copy)
    else $error("copy held for more than one cycle");

  // first edge of reset still sees power-up values
  en_low_in_reset: assert property (@(posedge wr_clk)
    (reset && $past(reset)) |-> (!wb.lane[0].en && !wb.lane[1].en))
    else $error("write enable high during reset");

endmodule

/* verification/pipe_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the two-lane pipeline
//   stimulus table with expected values, sent by a four-phase producer
//   reference register file and snapshot, lfsr immediates
//   writeback compare and cycle timeout
////////////////////////////////////////////////////////////////////////////

module pipe_tb import pipe_pkg::*; ();

  localparam int reg_count = 8;          // 2**idx_width at default widths

  typedef struct packed {
    bundle_t     b;                      // bundle to send
    logic [1:0]  mode;                   // 0 model, 1 model and table, 2 random imm
    logic [15:0] exp0;                   // table value, lane 0
    logic [15:0] exp1;                   // table value, lane 1
  } row_t;

  logic    wr_clk;
  logic    reset;
  logic    req;
  logic    ack;
  bundle_t bundle_in;
  wb_t     wb_out;

  row_t        table_q[$];               // stimulus rows
  logic [15:0] ref_regs [reg_count];     // reference register file
  logic [15:0] ref_snap [reg_count];     // reference snapshot
  logic        exp_en   [num_lanes];
  logic [15:0] exp_data [num_lanes];
  logic [31:0] lfsr;
  int          cycles = 0;
  int          limit = 1000;             // replaced once the table is built
  bit          verdict_printed;

  pipe_top UUT (
    .wr_clk, .reset, .req, .ack, .bundle_in, .wb_out
  );

  // checker sees regfile and issue stage signals from the top level
  bind pipe_top pipe_checker u_checker (
    .wr_clk(wr_clk), .reset(reset), .req(req), .ack(ack), .copy(copy),
    .r0(u_regfile.regs[0]), .wb(wb)
  );

  initial begin
    wr_clk = 1'b0;
    forever #20 wr_clk = ~wr_clk;        // period 40
  end

  always @(posedge wr_clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: the DUT did not finish within %0d cycles", limit);
      verdict_printed = 1'b1;
      $display("Done: errors found");
      $fatal(1, "run stopped on timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);            // one step per bit
      r = {r[14:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, actual, expected);
      verdict_printed = 1'b1;
      $display("Done: errors found");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic add_row(
    input bundle_kind_e kind,
    input op_e op0, input logic [2:0] d0, input logic [2:0] a0, input logic [2:0] b0,
    input logic [15:0] i0,
    input op_e op1, input logic [2:0] d1, input logic [2:0] a1, input logic [2:0] b1,
    input logic [15:0] i1,
    input logic [1:0] mode, input logic [15:0] e0, input logic [15:0] e1
  );
    row_t r;
    r.b.kind    = kind;
    r.b.lane[0] = '{op0, d0, a0, b0, i0};
    r.b.lane[1] = '{op1, d1, a1, b1, i1};
    r.mode      = mode;
    r.exp0      = e0;
    r.exp1      = e1;
    table_q.push_back(r);
  endtask

  // kind, lane 0 op dest a b imm, lane 1 op dest a b imm, mode, expected data
  task automatic build_table();
    add_row(bk_restore, op_nop, 0, 0, 0, 0, op_nop, 0, 0, 0, 0, 0, 0, 0);  // zero snapshot
    add_row(bk_exec, op_add, 0, 1, 2, 0, op_add, 0, 3, 4, 0, 1, 'h0000, 'h0000);
    add_row(bk_exec, op_add, 0, 5, 6, 0, op_add, 0, 7, 0, 0, 1, 'h0000, 'h0000);
    add_row(bk_exec, op_ldi, 1, 0, 0, 'hfff0, op_ldi, 2, 0, 0, 'h0025, 1, 'hfff0, 'h0025);
    add_row(bk_exec, op_add, 3, 1, 2, 0, op_sub, 4, 2, 1, 0, 1, 'h0015, 'h0035);  // wrap
    add_row(bk_exec, op_and, 5, 1, 2, 0, op_xor, 6, 1, 2, 0, 1, 'h0020, 'hffd5);
    add_row(bk_exec, op_ldi, 0, 0, 0, 'h1234, op_add, 7, 0, 0, 0, 1, 'h1234, 'h0000);
    add_row(bk_exec, op_add, 7, 0, 1, 0, op_add, 0, 0, 0, 0, 1, 'hfff0, 'h0000);  // r0 still 0
    add_row(bk_exec, op_ldi, 5, 0, 0, 'h1111, op_ldi, 5, 0, 0, 'h2222, 1, 'h1111, 'h2222);
    add_row(bk_exec, op_add, 6, 5, 0, 0, op_nop, 0, 0, 0, 0, 1, 'h2222, 'h0000);  // lane 1 won
    add_row(bk_exec, op_ldi, 3, 0, 0, 'h0abc, op_add, 4, 3, 0, 0, 1, 'h0abc, 'h0015);
    add_row(bk_exec, op_add, 1, 1, 3, 0, op_nop, 0, 0, 0, 0, 1, 'h0aac, 'h0000);  // chain
    add_row(bk_exec, op_sub, 2, 1, 4, 0, op_nop, 0, 0, 0, 0, 1, 'h0a97, 'h0000);
    add_row(bk_exec, op_xor, 3, 2, 1, 0, op_and, 4, 2, 7, 0, 1, 'h003b, 'h0a90);
    add_row(bk_exec, op_add, 5, 3, 4, 0, op_nop, 0, 0, 0, 0, 1, 'h0acb, 'h0000);
    add_row(bk_exec, op_ldi, 1, 0, 0, 0, op_ldi, 2, 0, 0, 0, 2, 0, 0);           // lfsr imm
    add_row(bk_exec, op_add, 3, 1, 2, 0, op_xor, 4, 1, 2, 0, 0, 0, 0);
    add_row(bk_save, op_nop, 0, 0, 0, 0, op_nop, 0, 0, 0, 0, 0, 0, 0);
    add_row(bk_exec, op_ldi, 1, 0, 0, 'h5555, op_ldi, 3, 0, 0, 'haaaa, 1, 'h5555, 'haaaa);
    add_row(bk_exec, op_ldi, 4, 0, 0, 'h0001, op_add, 5, 1, 3, 0, 1, 'h0001, 'hffff);
    add_row(bk_restore, op_nop, 0, 0, 0, 0, op_nop, 0, 0, 0, 0, 0, 0, 0);
    add_row(bk_exec, op_add, 0, 1, 0, 0, op_add, 0, 3, 0, 0, 0, 0, 0);          // read back
    add_row(bk_exec, op_add, 0, 4, 0, 0, op_add, 0, 5, 0, 0, 0, 0, 0);
    add_row(bk_exec, op_add, 0, 2, 0, 0, op_add, 0, 6, 0, 0, 0, 0, 0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model and producer
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_step(input bundle_t b);
    logic [15:0] a;
    logic [15:0] c;
    for (int l = 0; l < num_lanes; l++) begin
      a = ref_regs[b.lane[l].src_a];     // both lanes read old values
      c = ref_regs[b.lane[l].src_b];
      exp_en[l] = (b.kind == bk_exec) && (b.lane[l].op != op_nop);
      case (b.lane[l].op)
        op_add:  exp_data[l] = a + c;
        op_sub:  exp_data[l] = a - c;
        op_and:  exp_data[l] = a & c;
        op_xor:  exp_data[l] = a ^ c;
        op_ldi:  exp_data[l] = b.lane[l].imm;
        default: exp_data[l] = '0;
      endcase
    end
    for (int l = 0; l < num_lanes; l++) begin
      if (exp_en[l] && (b.lane[l].dest != zero_reg))
        ref_regs[b.lane[l].dest] = exp_data[l];  // lane 1 last
    end
    if (b.kind == bk_save)
      ref_snap = ref_regs;
    else if (b.kind == bk_restore)
      ref_regs = ref_snap;
  endtask

  // called just after a falling edge, returns just after one
  task automatic send_row(input int n);
    row_t r;
    r = table_q[n];
    if (r.mode == 2) begin
      r.b.lane[0].imm = take_bits(16);
      r.b.lane[1].imm = take_bits(16);
    end
    model_step(r.b);
    bundle_in = r.b;
    req = 1'b1;
    @(negedge wr_clk);
    while (!ack) @(negedge wr_clk);      // captured
    req = 1'b0;
    @(negedge wr_clk);
    while (!wb_out.valid) @(negedge wr_clk);
    for (int l = 0; l < num_lanes; l++) begin
      check(wb_out.lane[l].en, exp_en[l], $sformatf("row %0d lane %0d en", n, l));
      if (exp_en[l]) begin
        check(wb_out.lane[l].dest, r.b.lane[l].dest, $sformatf("row %0d lane %0d dest", n, l));
        check(wb_out.lane[l].data, exp_data[l], $sformatf("row %0d lane %0d data", n, l));
        if (r.mode == 1)
          check(wb_out.lane[l].data, (l == 0) ? r.exp0 : r.exp1,
                $sformatf("row %0d lane %0d table value", n, l));
      end
    end
    while (ack) @(negedge wr_clk);       // phase 4 before next req
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset           = 1'b1;
    req             = 1'b0;
    bundle_in       = '0;
    lfsr            = 32'h3d61;
    verdict_printed = 1'b0;
    for (int i = 0; i < reg_count; i++) begin
      ref_regs[i] = '0;
      ref_snap[i] = '0;
    end
    build_table();
    limit = table_q.size() * 8 + 5 + 20;
    repeat (5) @(negedge wr_clk);
    reset = 1'b0;
    repeat (4) begin                     // idle, nothing retired yet
      @(negedge wr_clk);
      check(wb_out.valid, 1'b0, "wb_out.valid before the first bundle");
    end
    for (int n = 0; n < table_q.size(); n++)
      send_row(n);
    verdict_printed = 1'b1;
    $display("Done: no errors");
    $finish;
  end

  final begin
    if (!verdict_printed)
      $display("Done: errors found");   // run cut short by an assertion
  end

endmodule

/* sources.f */
source/pipe_pkg.sv
source/regfile.sv
source/issue_stage.sv
source/exec_stage.sv
source/checkpoint_unit.sv
source/pipe_top.sv
verification/pipe_checker.sv
verification/pipe_tb.sv

/* Makefile */
# Verilator build and run for the two-lane pipeline testbench

VERILATOR ?= verilator
TOP       ?= pipe_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "$(PASS_MSG)"; then \
	  echo "test passed"; \
	else \
	  echo "test failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
